// ==== include/arm_config.svh ====
`ifndef ARM_CONFIG_SVH
`define ARM_CONFIG_SVH

// Datapath and address width
`define DATA_WIDTH 32

// Architectural registers R0..R15
`define REG_COUNT 16

// R15 reads as PC+8, writes redirect the PC
`define PC_REG 15

// Bytes per instruction
`define PC_STEP 4

`endif

// ==== hw/armPkg.sv ====
package armPkg;

   // Major opcode, bits 27:26
   typedef enum logic [1:0] {
      OP_DP  = 2'b00,
      OP_MEM = 2'b01,
      OP_BR  = 2'b10
   } opT;

   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,
      ALU_AND = 2'b10,
      ALU_ORR = 2'b11
   } aluOpT;

   typedef enum logic [1:0] {
      IMM8  = 2'b00,   // Data-processing, zero extended
      IMM12 = 2'b01,   // LDR/STR offset, zero extended
      IMM24 = 2'b10    // Branch word offset, sign extended
   } immSrcT;

   typedef struct packed {
      logic [3:0]  cond;
      opT          op;
      logic        imm;
      logic [3:0]  cmd;
      logic        s;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand2;   // imm8 or rm in the low bits
   } dpInstrT;

   typedef struct packed {
      logic [3:0]  cond;
      opT          op;
      logic [5:0]  funct;      // L bit is funct[0]
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] imm12;
   } memInstrT;

   typedef struct packed {
      logic [3:0]  cond;
      opT          op;
      logic [1:0]  funct;
      logic [23:0] imm24;
   } brInstrT;

   // One instruction word, three views
   typedef union packed {
      dpInstrT  dp;
      memInstrT mem;
      brInstrT  br;
   } instrT;

   typedef struct packed {
      logic neg;
      logic zero;
      logic carry;
      logic overflow;
   } flagsT;

   typedef struct packed {
      logic [1:0] regSrc;      // [0] R15 on port A, [1] rd on port B
      immSrcT     immSrc;
      logic       aluSrc;
      logic       memToReg;
      logic       regW;
      logic       memW;
      logic       pcS;
      logic [1:0] flagW;       // [1] N,Z  [0] C,V
      aluOpT      aluOp;
      logic       memStrobe;
   } ctrlT;

   // Controls after the condition check
   typedef struct packed {
      logic       regWrite;
      logic       memWrite;
      logic       pcSrc;
      logic [1:0] flagWrite;
   } commitT;

endpackage

// ==== hw/armDecode.sv ====
`timescale 1ns/1ps
`include "arm_config.svh"

module armDecode import armPkg::*; (
   input  instrT instr,
   output ctrlT  ctrl
);

   logic branch;
   logic dpOp;      // ALU decoder active
   logic regWRaw;   // Register write before the R15 redirect
   logic toPc;

   always_comb begin
      // Main decoder
      ctrl.regSrc    = 2'b00;
      ctrl.immSrc    = IMM8;
      ctrl.aluSrc    = 1'b0;
      ctrl.memToReg  = 1'b0;
      ctrl.memW      = 1'b0;
      ctrl.memStrobe = 1'b0;
      regWRaw        = 1'b0;
      branch         = 1'b0;
      dpOp           = 1'b0;
      case (instr.dp.op)
         OP_DP: begin
            ctrl.aluSrc = instr.dp.imm;   // imm8 or rm
            regWRaw     = 1'b1;
            dpOp        = 1'b1;
         end
         OP_MEM: begin
            ctrl.immSrc    = IMM12;
            ctrl.aluSrc    = 1'b1;
            ctrl.memStrobe = 1'b1;
            if (instr.mem.funct[0]) begin   // LDR
               ctrl.memToReg = 1'b1;
               regWRaw       = 1'b1;
            end else begin                  // STR, rd on port B
               ctrl.regSrc[1] = 1'b1;
               ctrl.memW      = 1'b1;
            end
         end
         OP_BR: begin
            ctrl.regSrc[0] = 1'b1;   // Target base is PC+8
            ctrl.immSrc    = IMM24;
            ctrl.aluSrc    = 1'b1;
            branch         = 1'b1;
         end
         default: ;
      endcase

      // ALU decoder
      ctrl.aluOp = ALU_ADD;   // Address and branch target
      ctrl.flagW = 2'b00;
      if (dpOp) begin
         case (instr.dp.cmd)
            4'b0100: ctrl.aluOp = ALU_ADD;
            4'b0010: ctrl.aluOp = ALU_SUB;
            4'b0000: ctrl.aluOp = ALU_AND;
            4'b1100: ctrl.aluOp = ALU_ORR;
            default: ctrl.aluOp = ALU_ADD;
         endcase
         ctrl.flagW[1] = instr.dp.s;
         ctrl.flagW[0] = instr.dp.s & (ctrl.aluOp inside {ALU_ADD, ALU_SUB});
      end

      // A write to R15 becomes a jump
      toPc      = regWRaw & (instr.dp.rd == `PC_REG);
      ctrl.regW = regWRaw & ~toPc;
      ctrl.pcS  = branch | toPc;
   end

   always_comb begin
      if (!$isunknown(instr)) begin
         assert final (instr.dp.op inside {OP_DP, OP_MEM, OP_BR})
            else $error("armDecode: unsupported opcode %b", instr.dp.op);
         assert final (instr.dp.op != OP_DP ||
                       instr.dp.cmd inside {4'b0100, 4'b0010, 4'b0000, 4'b1100})
            else $error("armDecode: unsupported cmd %b", instr.dp.cmd);
      end
   end

endmodule

// ==== hw/armCondUnit.sv ====
`timescale 1ns/1ps

module armCondUnit import armPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       pcReady,
   input  logic [3:0] cond,
   input  ctrlT       ctrl,
   input  flagsT      aluFlags,
   output commitT     commit
);

   flagsT flags;   // Stored NZCV
   logic  condEx;
   logic  ge;
   logic  update;  // Condition passed and not stalled

   // N,Z and C,V load separately
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= '0;
      end else begin
         if (commit.flagWrite[1]) begin
            flags.neg  <= aluFlags.neg;
            flags.zero <= aluFlags.zero;
         end
         if (commit.flagWrite[0]) begin
            flags.carry    <= aluFlags.carry;
            flags.overflow <= aluFlags.overflow;
         end
      end
   end

   assign ge = (flags.neg == flags.overflow);

   always_comb begin
      case (cond)
         4'b0000: condEx = flags.zero;                    // EQ
         4'b0001: condEx = ~flags.zero;                   // NE
         4'b0010: condEx = flags.carry;                   // CS
         4'b0011: condEx = ~flags.carry;                  // CC
         4'b0100: condEx = flags.neg;                     // MI
         4'b0101: condEx = ~flags.neg;                    // PL
         4'b0110: condEx = flags.overflow;                // VS
         4'b0111: condEx = ~flags.overflow;               // VC
         4'b1000: condEx = flags.carry & ~flags.zero;     // HI
         4'b1001: condEx = ~(flags.carry & ~flags.zero);  // LS
         4'b1010: condEx = ge;                            // GE
         4'b1011: condEx = ~ge;                           // LT
         4'b1100: condEx = ~flags.zero & ge;              // GT
         4'b1101: condEx = ~(~flags.zero & ge);           // LE
         4'b1110: condEx = 1'b1;                          // AL
         default: condEx = 1'b0;
      endcase
   end

   // PC is enabled by pcReady in armPcUnit, memory samples pcReady itself
   assign update = condEx & pcReady;
   assign commit = '{regWrite:  ctrl.regW & update,
                     memWrite:  ctrl.memW & condEx,
                     pcSrc:     ctrl.pcS & condEx,
                     flagWrite: ctrl.flagW & {2{update}}};

   assert property (@(posedge clk) disable iff (reset) commit.memWrite |-> ctrl.memStrobe)
      else $error("armCondUnit: memWrite without memStrobe");

endmodule

// ==== hw/armExecute.sv ====
`timescale 1ns/1ps
`include "arm_config.svh"

module armExecute import armPkg::*; (
   input  instrT                  instr,
   input  ctrlT                   ctrl,
   input  logic [`DATA_WIDTH-1:0] srcA,
   input  logic [`DATA_WIDTH-1:0] writeData,
   output logic [`DATA_WIDTH-1:0] aluResult,
   output flagsT                  aluFlags
);

   localparam int DW = `DATA_WIDTH;

   logic [DW-1:0] extImm;
   logic [DW-1:0] srcB;
   logic [DW-1:0] condInvB;
   logic [DW:0]   sum;      // Carry out in the top bit
   logic          sub;
   logic          arith;

   always_comb begin
      case (ctrl.immSrc)
         IMM8:    extImm = {{(DW-8){1'b0}}, instr.dp.operand2[7:0]};
         IMM12:   extImm = {{(DW-12){1'b0}}, instr.mem.imm12};
         // Word offset, shifted to bytes
         IMM24:   extImm = {{(DW-26){instr.br.imm24[23]}}, instr.br.imm24, 2'b00};
         default: extImm = '0;
      endcase
   end

   assign srcB = ctrl.aluSrc ? extImm : writeData;   // Immediate or rm

   // SUB as A + ~B + 1 on the same adder
   assign sub      = (ctrl.aluOp == ALU_SUB);
   assign arith    = ctrl.aluOp inside {ALU_ADD, ALU_SUB};
   assign condInvB = sub ? ~srcB : srcB;
   assign sum      = {1'b0, srcA} + {1'b0, condInvB} + {{DW{1'b0}}, sub};

   always_comb begin
      case (ctrl.aluOp)
         ALU_ADD, ALU_SUB: aluResult = sum[DW-1:0];
         ALU_AND:          aluResult = srcA & srcB;
         ALU_ORR:          aluResult = srcA | srcB;
         default:          aluResult = sum[DW-1:0];
      endcase
   end

   // C and V only meaningful for the adder
   assign aluFlags = '{neg:      aluResult[DW-1],
                       zero:     (aluResult == '0),
                       carry:    arith & sum[DW],
                       overflow: arith & ~(srcA[DW-1] ^ srcB[DW-1] ^ sub) &
                                 (srcA[DW-1] ^ sum[DW-1])};

endmodule

// ==== hw/armRegFile.sv ====
`timescale 1ns/1ps
`include "arm_config.svh"

module armRegFile import armPkg::*; (
   input  logic                   clk,
   input  instrT                  instr,
   input  ctrlT                   ctrl,
   input  commitT                 commit,
   input  logic [`DATA_WIDTH-1:0] aluResult,
   input  logic [`DATA_WIDTH-1:0] readData,
   input  logic [`DATA_WIDTH-1:0] pcPlus8,
   output logic [`DATA_WIDTH-1:0] srcA,
   output logic [`DATA_WIDTH-1:0] writeData,
   output logic [`DATA_WIDTH-1:0] result
);

   localparam int ADDR_W = $clog2(`REG_COUNT);

   // R0..R14 only, R15 comes from the PC
   logic [`DATA_WIDTH-1:0] regs [`REG_COUNT-1];
   logic [ADDR_W-1:0]      ra1;
   logic [ADDR_W-1:0]      ra2;

   assign ra1 = ctrl.regSrc[0] ? ADDR_W'(`PC_REG) : instr.dp.rn;
   assign ra2 = ctrl.regSrc[1] ? instr.dp.rd : instr.dp.operand2[3:0];   // rd for STR

   assign srcA      = (ra1 == ADDR_W'(`PC_REG)) ? pcPlus8 : regs[ra1];
   assign writeData = (ra2 == ADDR_W'(`PC_REG)) ? pcPlus8 : regs[ra2];

   // Load data or ALU output
   assign result = ctrl.memToReg ? readData : aluResult;

   always_ff @(posedge clk) begin
      if (commit.regWrite) begin
         regs[instr.dp.rd] <= result;
      end
   end

   // R15 writes must have been turned into a PC load by the decoder
   assert property (@(posedge clk) commit.regWrite |-> instr.dp.rd != `PC_REG)
      else $error("armRegFile: register write addressed to R15");

endmodule

// ==== hw/armPcUnit.sv ====
`timescale 1ns/1ps
`include "arm_config.svh"

module armPcUnit (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   pcReady,
   input  logic                   pcSrc,
   input  logic [`DATA_WIDTH-1:0] result,
   output logic [`DATA_WIDTH-1:0] pc,
   output logic [`DATA_WIDTH-1:0] pcPlus8
);

   logic [`DATA_WIDTH-1:0] pcPlus4;
   logic [`DATA_WIDTH-1:0] pcNext;

   assign pcPlus4 = pc + `DATA_WIDTH'(`PC_STEP);
   assign pcPlus8 = pcPlus4 + `DATA_WIDTH'(`PC_STEP);   // Value seen as R15
   assign pcNext  = pcSrc ? result : pcPlus4;           // Branch or R15 write

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= '0;
      end else if (pcReady) begin
         pc <= pcNext;
      end
   end

endmodule

// ==== hw/armCore.sv ====
`timescale 1ns/1ps
`include "arm_config.svh"

module armCore import armPkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   pcReady,
   input  instrT                  instr,
   input  logic [`DATA_WIDTH-1:0] readData,
   output logic [`DATA_WIDTH-1:0] pc,
   output logic [`DATA_WIDTH-1:0] aluResult,   // Also the memory address
   output logic [`DATA_WIDTH-1:0] writeData,
   output logic                   memWrite,
   output logic                   memStrobe
);

   ctrlT                   ctrl;
   commitT                 commit;
   flagsT                  aluFlags;
   logic [`DATA_WIDTH-1:0] srcA;
   logic [`DATA_WIDTH-1:0] result;
   logic [`DATA_WIDTH-1:0] pcPlus8;

   armDecode uDecode (.instr(instr), .ctrl(ctrl));

   armCondUnit uCond (
      .clk(clk), .reset(reset), .pcReady(pcReady),
      .cond(instr.dp.cond), .ctrl(ctrl), .aluFlags(aluFlags), .commit(commit)
   );

   armExecute uExecute (
      .instr(instr), .ctrl(ctrl), .srcA(srcA), .writeData(writeData),
      .aluResult(aluResult), .aluFlags(aluFlags)
   );

   armRegFile uRegFile (
      .clk(clk), .instr(instr), .ctrl(ctrl), .commit(commit),
      .aluResult(aluResult), .readData(readData), .pcPlus8(pcPlus8),
      .srcA(srcA), .writeData(writeData), .result(result)
   );

   armPcUnit uPc (
      .clk(clk), .reset(reset), .pcReady(pcReady), .pcSrc(commit.pcSrc),
      .result(result), .pc(pc), .pcPlus8(pcPlus8)
   );

   assign memWrite  = commit.memWrite;
   assign memStrobe = ctrl.memStrobe;   // Any LDR/STR, condition ignored

endmodule

// ==== verification/armModel.svh ====
`ifndef ARM_MODEL_SVH
`define ARM_MODEL_SVH

localparam int DW = `DATA_WIDTH;

// Outputs expected while one instruction is presented
typedef struct packed {
   logic [DW-1:0] pc;
   logic [DW-1:0] aluResult;
   logic [DW-1:0] writeData;
   logic          memWrite;
   logic          memStrobe;
} expectT;

logic [DW-1:0] mRegs [15];   // R0..R14
logic [DW-1:0] mMem [64];
logic [DW-1:0] mPc;
flagsT         mFlags;

// Pending effects of the presented instruction, applied at a ready edge
logic [DW-1:0] nextPc;
flagsT         nextFlags;
logic          regWe;
logic [3:0]    regIdx;
logic [DW-1:0] regVal;
logic          memWe;
logic [5:0]    memIdx;
logic [DW-1:0] memVal;

task automatic resetModel();
   mPc    = '0;
   mFlags = '0;
   for (int i = 0; i < 64; i++) begin
      mMem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0203);   // Pattern over the whole index
   end
endtask

function automatic logic [DW-1:0] readReg(input logic [3:0] idx);
   if (idx == `PC_REG) begin
      return mPc + DW'(8);   // Two instructions ahead
   end
   return mRegs[idx];
endfunction

function automatic logic condPass(input logic [3:0] cond, input flagsT f);
   logic base;
   case (cond[3:1])
      3'd0:    base = f.zero;                             // EQ/NE
      3'd1:    base = f.carry;                            // CS/CC
      3'd2:    base = f.neg;                              // MI/PL
      3'd3:    base = f.overflow;                         // VS/VC
      3'd4:    base = f.carry && !f.zero;                 // HI/LS
      3'd5:    base = (f.neg == f.overflow);              // GE/LT
      3'd6:    base = !f.zero && (f.neg == f.overflow);   // GT/LE
      default: return 1'b1;                               // AL
   endcase
   return base ^ cond[0];   // Odd codes invert
endfunction

task automatic predict(input instrT ins, output expectT e);
   logic [DW-1:0] a;
   logic [DW-1:0] b;
   logic [DW-1:0] r;
   logic [DW:0]   wide;
   logic          pass;
   logic          arith;
   logic          c;
   logic          v;
   pass        = condPass(ins.dp.cond, mFlags);
   e.pc        = mPc;
   e.memWrite  = 1'b0;
   e.memStrobe = (ins.dp.op == OP_MEM);
   // Only STR reads rd on the second port
   e.writeData = readReg((ins.dp.op == OP_MEM && !ins.mem.funct[0]) ?
                         ins.mem.rd : ins.dp.operand2[3:0]);
   nextPc      = mPc + DW'(`PC_STEP);
   nextFlags   = mFlags;
   regWe       = 1'b0;
   regIdx      = ins.dp.rd;
   memWe       = 1'b0;
   memVal      = e.writeData;
   case (ins.dp.op)
      OP_DP: begin
         a     = readReg(ins.dp.rn);
         b     = ins.dp.imm ? DW'(ins.dp.operand2[7:0]) : readReg(ins.dp.operand2[3:0]);
         arith = 1'b0;
         c     = 1'b0;
         v     = 1'b0;
         case (ins.dp.cmd)
            4'b0100: begin
               wide  = {1'b0, a} + {1'b0, b};
               r     = wide[DW-1:0];
               c     = wide[DW];
               v     = (a[DW-1] == b[DW-1]) && (r[DW-1] != a[DW-1]);
               arith = 1'b1;
            end
            4'b0010: begin
               r     = a - b;
               c     = (a >= b);   // No borrow
               v     = (a[DW-1] != b[DW-1]) && (r[DW-1] != a[DW-1]);
               arith = 1'b1;
            end
            4'b0000: r = a & b;
            default: r = a | b;
         endcase
         e.aluResult = r;
         if (pass && ins.dp.s) begin
            nextFlags.neg  = r[DW-1];
            nextFlags.zero = (r == '0);
            if (arith) begin   // AND and ORR keep C and V
               nextFlags.carry    = c;
               nextFlags.overflow = v;
            end
         end
         if (pass && ins.dp.rd == `PC_REG) begin
            nextPc = r;
         end else begin
            regWe  = pass;
            regVal = r;
         end
      end
      OP_MEM: begin
         e.aluResult = readReg(ins.mem.rn) + DW'(ins.mem.imm12);
         memIdx      = e.aluResult[7:2];
         if (ins.mem.funct[0]) begin   // LDR
            regWe  = pass;
            regVal = mMem[memIdx];
         end else begin
            e.memWrite = pass;
            memWe      = pass;
         end
      end
      default: begin
         e.aluResult = mPc + DW'(8) + (DW'($signed(ins.br.imm24)) << 2);
         if (pass) begin
            nextPc = e.aluResult;
         end
      end
   endcase
endtask

task automatic commitModel();
   mPc    = nextPc;
   mFlags = nextFlags;
   if (regWe) begin
      mRegs[regIdx] = regVal;
   end
   if (memWe) begin
      mMem[memIdx] = memVal;
   end
endtask

`endif

// ==== verification/armCoreTb.sv ====
`timescale 1ns/1ps
`include "arm_config.svh"

module armCoreTb import armPkg::*; ();

   localparam int NUM_INSTR   = 2000;
   localparam int STALL_LIMIT = 40;   // Cycles of pcReady low per instruction

   logic                   clk;
   logic                   reset;
   logic                   pcReady;
   instrT                  instr;
   logic [`DATA_WIDTH-1:0] readData;
   logic [`DATA_WIDTH-1:0] pc;
   logic [`DATA_WIDTH-1:0] aluResult;
   logic [`DATA_WIDTH-1:0] writeData;
   logic                   memWrite;
   logic                   memStrobe;
   string                  testName;

   `include "armModel.svh"

   armCore DUT (
      .clk(clk), .reset(reset), .pcReady(pcReady), .instr(instr), .readData(readData),
      .pc(pc), .aluResult(aluResult), .writeData(writeData),
      .memWrite(memWrite), .memStrobe(memStrobe)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stopRun();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic mismatch(input string sig, input logic [127:0] expected,
                           input logic [127:0] actual);
      $display("MISMATCH %s %s: expected %0h actual %0h", testName, sig, expected, actual);
      stopRun();
   endtask

   task automatic checkOutputs(input expectT e);
      assert (pc === e.pc) else mismatch("pc", e.pc, pc);
      assert (aluResult === e.aluResult) else mismatch("aluResult", e.aluResult, aluResult);
      assert (writeData === e.writeData) else mismatch("writeData", e.writeData, writeData);
      assert (memWrite === e.memWrite) else mismatch("memWrite", e.memWrite, memWrite);
      assert (memStrobe === e.memStrobe) else mismatch("memStrobe", e.memStrobe, memStrobe);
   endtask

   // ADD rN, r15, #imm gives each register a known value
   function automatic instrT initInstr(input int n);
      instrT w;
      w             = '0;
      w.dp.cond     = 4'hE;
      w.dp.op       = OP_DP;
      w.dp.imm      = 1'b1;
      w.dp.cmd      = 4'b0100;
      w.dp.rn       = `PC_REG;
      w.dp.rd       = 4'(n);
      w.dp.operand2 = {4'h0, 4'($urandom_range(15)), 4'hF};   // Port B reads R15
      return w;
   endfunction

   task automatic makeInstr(output instrT w);
      logic [3:0] cmds [4] = '{4'b0100, 4'b0010, 4'b0000, 4'b1100};
      int         kind;
      kind      = $urandom_range(99);
      w         = '0;
      w.dp.cond = $urandom_range(1) ? 4'hE : 4'($urandom_range(14));   // AL half the time
      if (kind < 50) begin
         testName      = "dataProc";
         w.dp.op       = OP_DP;
         w.dp.imm      = 1'($urandom_range(1));
         w.dp.cmd      = cmds[$urandom_range(3)];
         w.dp.s        = 1'($urandom_range(1));
         w.dp.rn       = 4'($urandom_range(15));
         w.dp.rd       = 4'($urandom_range(11));   // R12..R14 stay memory bases
         w.dp.operand2 = w.dp.imm ? 12'($urandom_range(255)) : 12'($urandom_range(15));
      end else if (kind < 75) begin
         w.mem.op    = OP_MEM;
         w.mem.funct = {5'b01100, 1'($urandom_range(1))};
         testName    = w.mem.funct[0] ? "load" : "store";
         w.mem.rn    = 4'(12 + $urandom_range(2));
         w.mem.rd    = w.mem.funct[0] ? 4'($urandom_range(11)) : 4'($urandom_range(15));
         w.mem.imm12 = 12'($urandom_range(255));
      end else if (kind < 88) begin
         testName   = "branch";
         w.br.op    = OP_BR;
         w.br.funct = 2'b10;
         w.br.imm24 = 24'(int'($urandom_range(15)) - 8);   // -8..7 words
      end else begin
         testName      = "r15Jump";
         w.dp.op       = OP_DP;
         w.dp.imm      = 1'b1;
         w.dp.cmd      = 4'b0100;
         w.dp.rn       = `PC_REG;
         w.dp.rd       = `PC_REG;
         w.dp.operand2 = 12'($urandom_range(63) * 4);
      end
   endtask

   // Present one instruction until an edge with pcReady high commits it
   task automatic runInstruction(input instrT ins);
      expectT e;
      int     stalls;
      logic   ready;
      stalls = 0;
      ready  = 1'b0;
      while (!ready) begin
         predict(ins, e);
         ready    = ($urandom_range(4) != 0);   // Low about a fifth of the time
         instr    = ins;
         pcReady  = ready;
         readData = mMem[e.aluResult[7:2]];
         @(negedge clk);
         checkOutputs(e);   // Same expectation on every stalled cycle
         @(posedge clk);
         if (ready) begin
            commitModel();
         end
         #1;
         stalls++;
         if (!ready && stalls >= STALL_LIMIT) begin
            $display("Timeout: pcReady stayed low for %0d cycles at pc %h", stalls, mPc);
            stopRun();
         end
      end
   endtask

   initial begin
      instrT randInstr;
      reset    = 1'b1;
      pcReady  = 1'b0;
      instr    = '0;
      readData = '0;
      testName = "reset";
      void'($urandom(32'hdd55));
      resetModel();
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      assert (pc === '0) else mismatch("pc", 0, pc);
      for (int n = 0; n < NUM_INSTR; n++) begin
         if (n < `PC_REG) begin
            testName = "init";
            runInstruction(initInstr(n));
         end else begin
            makeInstr(randInstr);
            runInstruction(randInstr);
         end
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+include
+incdir+verification
hw/armPkg.sv
hw/armDecode.sv
hw/armCondUnit.sv
hw/armExecute.sv
hw/armRegFile.sv
hw/armPcUnit.sv
hw/armCore.sv
verification/armCoreTb.sv
